// File: design/gb_io_pkg.sv
// package for the i/o block: widths, address map, select, interrupt and serial enums
package gb_io_pkg;

	// ----------------------------------------------------------
	// widths
	// ----------------------------------------------------------
	localparam int ADDR_W  = 16;	// cpu address bus
	localparam int DATA_W  = 8;	// cpu data bus
	localparam int IRQ_W   = 5;	// interrupt sources in IF/IE
	localparam int HRAM_AW = 7;	// zero page ram index

	// ----------------------------------------------------------
	// i/o page address map
	// ----------------------------------------------------------
	localparam logic [ADDR_W-1:0] ADDR_P1   = 16'hFF00;	// joypad
	localparam logic [ADDR_W-1:0] ADDR_SB   = 16'hFF01;	// serial data, open bus here
	localparam logic [ADDR_W-1:0] ADDR_SC   = 16'hFF02;	// serial control
	localparam logic [ADDR_W-1:0] ADDR_IF   = 16'hFF0F;	// interrupt flags
	localparam logic [ADDR_W-1:0] ADDR_IE   = 16'hFFFF;	// interrupt enable
	localparam logic [ADDR_W-1:0] HRAM_BASE = 16'hFF80;	// zero page ram, up to FFFE

	// which unit the current address hits
	typedef enum logic [2:0] {
		SEL_NONE,
		SEL_P1,
		SEL_SB,
		SEL_SC,
		SEL_IF,
		SEL_IE,
		SEL_HRAM
	} io_sel_e;

	// interrupt bit positions, lowest index wins
	typedef enum logic [2:0] {
		IRQ_VBLANK,
		IRQ_LCD,
		IRQ_TIMER,
		IRQ_SERIAL,
		IRQ_JOYPAD
	} irq_src_e;

	// rst vectors 40h, 48h, 50h, 58h, 60h
	localparam logic [DATA_W-1:0] VEC_BASE = 8'h40;
	localparam logic [DATA_W-1:0] VEC_STEP = 8'h08;
	localparam logic [DATA_W-1:0] VEC_NONE = 8'h55;	// nothing enabled and pending

	localparam logic [DATA_W-1:0] OPEN_BUS = 8'hFF;	// unmapped reads and SB

	// dummy serial port
	typedef enum logic {
		SER_IDLE,
		SER_SHIFT
	} serial_state_e;

endpackage

// File: design/io_bus_if.sv
// interface carrying the decoded cpu bus from the decoder to the i/o units
`timescale 1ns/1ps

interface io_bus_if import gb_io_pkg::*; ();

	logic [ADDR_W-1:0] addr;	// full cpu address
	logic [DATA_W-1:0] wdata;	// write data from cpu
	logic              wr;	// one cycle write strobe
	logic              rd;	// one cycle read strobe
	io_sel_e           sel;	// decoded target

	// address decoder side
	modport decoder (
		output addr,
		output wdata,
		output wr,
		output rd,
		output sel
	);

	// register and ram units
	modport unit (
		input addr,
		input wdata,
		input wr,
		input rd,
		input sel
	);

endinterface

// File: design/io_decode.sv
// address decoder, bus interface driver and registered read data mux
`timescale 1ns/1ps

module io_decode import gb_io_pkg::*; (
	input  logic              clk_cpu,
	input  logic              reset,
	input  logic [ADDR_W-1:0] cpu_addr,
	input  logic [DATA_W-1:0] cpu_wdata,
	input  logic              cpu_wr,
	input  logic              cpu_rd,
	input  logic [DATA_W-1:0] p1_rdata,
	input  logic [DATA_W-1:0] sc_rdata,
	input  logic [DATA_W-1:0] if_rdata,
	input  logic [DATA_W-1:0] ie_rdata,
	input  logic [DATA_W-1:0] hram_rdata,
	output logic [DATA_W-1:0] cpu_rdata,
	io_bus_if.decoder         bus
);

	io_sel_e           sel;
	logic [DATA_W-1:0] reg_rdata;	// register value picked by sel
	logic [DATA_W-1:0] rdata_q;	// captured on the read strobe
	logic              rd_hram_q;	// last read went to zero page ram

	// ----------------------------------------------------------
	// address decode
	// ----------------------------------------------------------
	always_comb begin
		case (cpu_addr)
			ADDR_P1: sel = SEL_P1;
			ADDR_SB: sel = SEL_SB;
			ADDR_SC: sel = SEL_SC;
			ADDR_IF: sel = SEL_IF;
			ADDR_IE: sel = SEL_IE;	// FFFF wins over the ram window
			default: begin
				if (cpu_addr[ADDR_W-1:HRAM_AW] == HRAM_BASE[ADDR_W-1:HRAM_AW])
					sel = SEL_HRAM;	// FF80..FFFE
				else
					sel = SEL_NONE;
			end
		endcase
	end

	assign bus.addr  = cpu_addr;
	assign bus.wdata = cpu_wdata;
	assign bus.wr    = cpu_wr;
	assign bus.rd    = cpu_rd;
	assign bus.sel   = sel;

	// ----------------------------------------------------------
	// read data
	// ----------------------------------------------------------
	always_comb begin
		case (sel)
			SEL_P1:  reg_rdata = p1_rdata;
			SEL_SC:  reg_rdata = sc_rdata;
			SEL_IF:  reg_rdata = if_rdata;
			SEL_IE:  reg_rdata = ie_rdata;
			default: reg_rdata = OPEN_BUS;	// SB, unmapped, hram handled below
		endcase
	end

	// registers are captured here, hram registers its own output
	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			rdata_q   <= OPEN_BUS;
			rd_hram_q <= 1'b0;
		end else if (cpu_rd) begin
			rdata_q   <= reg_rdata;
			rd_hram_q <= (sel == SEL_HRAM);
		end
	end

	assign cpu_rdata = rd_hram_q ? hram_rdata : rdata_q;

	// cpu never issues both strobes in one cycle
	a_no_wr_rd: assert property (@(posedge clk_cpu) disable iff (reset)
		!(cpu_wr && cpu_rd));

endmodule

// File: design/irq_ctrl.sv
// interrupt flag and enable registers, priority vector and clear on acknowledge
`timescale 1ns/1ps

module irq_ctrl import gb_io_pkg::*; (
	input  logic              clk_cpu,
	input  logic              reset,
	io_bus_if.unit            bus,
	input  logic              irq_ack,
	input  logic              vblank_irq,
	input  logic              lcd_irq,
	input  logic              timer_irq,
	input  logic              ser_irq,
	input  logic              joy_irq,
	output logic              irq_n,
	output logic [DATA_W-1:0] irq_vec,
	output logic [DATA_W-1:0] if_rdata,
	output logic [DATA_W-1:0] ie_rdata
);

	logic [IRQ_W-1:0] if_q;	// IF, FF0F
	logic [IRQ_W-1:0] ie_q;	// IE, FFFF
	logic [IRQ_W-1:0] if_set;	// event pulses this cycle
	logic [IRQ_W-1:0] pending;	// flagged and enabled
	logic [IRQ_W-1:0] clr_mask;	// one hot, highest priority pending
	logic             ack_q;
	logic             ack_fall;

	// event pulses into flag positions
	always_comb begin
		if_set             = '0;
		if_set[IRQ_VBLANK] = vblank_irq;
		if_set[IRQ_LCD]    = lcd_irq;
		if_set[IRQ_TIMER]  = timer_irq;
		if_set[IRQ_SERIAL] = ser_irq;
		if_set[IRQ_JOYPAD] = joy_irq;
	end

	assign pending  = if_q & ie_q;
	assign clr_mask = pending & (~pending + 1'b1);	// isolate lowest set bit
	assign ack_fall = ack_q & ~irq_ack;	// ack cycle just ended

	// ----------------------------------------------------------
	// registers
	// ----------------------------------------------------------
	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			if_q  <= '0;
			ie_q  <= '0;
			ack_q <= 1'b0;
		end else begin
			ack_q <= irq_ack;
			if (bus.wr && bus.sel == SEL_IF)
				if_q <= bus.wdata[IRQ_W-1:0];	// cpu write beats events
			else if (ack_fall)
				if_q <= (if_q & ~clr_mask) | if_set;
			else
				if_q <= if_q | if_set;
			if (bus.wr && bus.sel == SEL_IE)
				ie_q <= bus.wdata[IRQ_W-1:0];
		end
	end

	// unused upper bits read 1 in IF, 0 in IE
	assign if_rdata = {{(DATA_W-IRQ_W){1'b1}}, if_q};
	assign ie_rdata = {{(DATA_W-IRQ_W){1'b0}}, ie_q};

	// ----------------------------------------------------------
	// cpu side
	// ----------------------------------------------------------
	assign irq_n = ~|pending;

	// scan down so vblank ends up on top
	always_comb begin
		irq_vec = VEC_NONE;
		for (int i = IRQ_W - 1; i >= 0; i--) begin
			if (pending[i])
				irq_vec = VEC_BASE + DATA_W'(i) * VEC_STEP;
		end
	end

	// cpu acknowledges only while a real vector is offered
	a_ack_vec: assert property (@(posedge clk_cpu) disable iff (reset)
		irq_ack |-> irq_vec != VEC_NONE);

endmodule

// File: design/joypad.sv
// joypad P1 select register, key matrix read and key press interrupt
`timescale 1ns/1ps

module joypad import gb_io_pkg::*; (
	input  logic              clk_cpu,
	input  logic              reset,
	io_bus_if.unit            bus,
	input  logic [7:0]        joystick,	// active high, right..start
	output logic [DATA_W-1:0] p1_rdata,
	output logic              joy_irq
);

	logic [1:0] sel_q;	// P15 buttons, P14 directions, 0 enables
	logic [3:0] dir_n;	// right left up down, low active
	logic [3:0] btn_n;	// a b select start, low active
	logic [7:0] key_d1;	// inverted key lines, first stage
	logic [7:0] key_d2;	// second stage

	// group not selected reads all ones
	assign dir_n = ~joystick[3:0] | {4{sel_q[0]}};
	assign btn_n = ~joystick[7:4] | {4{sel_q[1]}};

	assign p1_rdata = {2'b11, sel_q, dir_n & btn_n};

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			sel_q   <= 2'b00;
			key_d1  <= '1;	// all released
			key_d2  <= '1;
			joy_irq <= 1'b0;
		end else begin
			if (bus.wr && bus.sel == SEL_P1)
				sel_q <= bus.wdata[5:4];
			key_d1  <= ~joystick;
			key_d2  <= key_d1;
			joy_irq <= |(key_d2 & ~key_d1);	// any line went low
		end
	end

endmodule

// File: design/serial_port.sv
// serial control register SC with bit time divider, bit counter and done interrupt
`timescale 1ns/1ps

module serial_port import gb_io_pkg::*; #(
	parameter int SER_DIV_W = 9	// bit time is 2**SER_DIV_W clocks
) (
	input  logic              clk_cpu,
	input  logic              reset,
	io_bus_if.unit            bus,
	output logic [DATA_W-1:0] sc_rdata,
	output logic              ser_irq
);

	localparam logic [3:0] BITS = 4'd8;	// one byte per transfer

	serial_state_e        state;
	logic                 sc_start;	// SC bit 7
	logic                 sc_clk_int;	// SC bit 0, internal clock
	logic [SER_DIV_W-1:0] div_q;
	logic [3:0]           bit_cnt;	// bits left
	logic                 sc_wr;

	assign sc_wr = bus.wr && (bus.sel == SEL_SC);

	// ----------------------------------------------------------
	// transfer sequencing, no data is actually shifted
	// ----------------------------------------------------------
	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			state      <= SER_IDLE;
			sc_start   <= 1'b0;
			sc_clk_int <= 1'b0;
			div_q      <= '1;
			bit_cnt    <= BITS;
			ser_irq    <= 1'b0;
		end else begin
			ser_irq <= 1'b0;
			if (sc_wr) begin
				sc_start   <= bus.wdata[7];
				sc_clk_int <= bus.wdata[0];
				div_q      <= '1;
				bit_cnt    <= BITS;
				// external clock never arrives so only internal runs
				state <= (bus.wdata[7] && bus.wdata[0]) ? SER_SHIFT : SER_IDLE;
			end else begin
				case (state)
					SER_IDLE: begin
						div_q   <= '1;
						bit_cnt <= BITS;
					end
					SER_SHIFT: begin
						div_q <= div_q - 1'b1;
						if (bit_cnt == 4'd0) begin	// final check cycle
							ser_irq  <= 1'b1;
							sc_start <= 1'b0;
							state    <= SER_IDLE;
						end else if (div_q == '0) begin
							bit_cnt <= bit_cnt - 1'b1;	// one bit time done
						end
					end
					default: state <= SER_IDLE;
				endcase
			end
		end
	end

	assign sc_rdata = {sc_start, {(DATA_W-2){1'b1}}, sc_clk_int};

	// last bit time ends exactly on a divider wrap
	a_bit_align: assert property (@(posedge clk_cpu) disable iff (reset)
		state == SER_SHIFT && bit_cnt == 4'd0 |-> div_q == '1);

endmodule

// File: design/hram.sv
// 127 byte zero page ram with registered read
`timescale 1ns/1ps

module hram import gb_io_pkg::*; (
	input  logic              clk_cpu,
	io_bus_if.unit            bus,
	output logic [DATA_W-1:0] hram_rdata
);

	localparam int DEPTH = (1 << HRAM_AW) - 1;	// FFFF belongs to IE

	logic [DATA_W-1:0] mem [DEPTH];
	logic [HRAM_AW-1:0] idx;

	assign idx = bus.addr[HRAM_AW-1:0];

	// read data held until the next ram read
	always_ff @(posedge clk_cpu) begin
		if (bus.sel == SEL_HRAM) begin
			if (bus.wr)
				mem[idx] <= bus.wdata;
			if (bus.rd)
				hram_rdata <= mem[idx];
		end
	end

endmodule

// File: design/gb_io_top.sv
// top level of the i/o and interrupt block, decoder and unit instances
`timescale 1ns/1ps

module gb_io_top import gb_io_pkg::*; #(
	parameter int SER_DIV_W = 9	// serial bit time divider width
) (
	input  logic              clk_cpu,
	input  logic              reset,
	// cpu bus
	input  logic [ADDR_W-1:0] cpu_addr,
	input  logic [DATA_W-1:0] cpu_wdata,
	input  logic              cpu_wr,
	input  logic              cpu_rd,
	output logic [DATA_W-1:0] cpu_rdata,
	// interrupt to cpu
	input  logic              irq_ack,
	output logic              irq_n,
	output logic [DATA_W-1:0] irq_vec,
	// keys and external events
	input  logic [7:0]        joystick,
	input  logic              vblank_irq,
	input  logic              lcd_irq,
	input  logic              timer_irq
);

	logic [DATA_W-1:0] p1_rdata;
	logic [DATA_W-1:0] sc_rdata;
	logic [DATA_W-1:0] if_rdata;
	logic [DATA_W-1:0] ie_rdata;
	logic [DATA_W-1:0] hram_rdata;
	logic              ser_irq;
	logic              joy_irq;

	io_bus_if bus ();

	io_decode i_decode (
		.clk_cpu, .reset, .cpu_addr, .cpu_wdata, .cpu_wr, .cpu_rd,
		.p1_rdata, .sc_rdata, .if_rdata, .ie_rdata, .hram_rdata,
		.cpu_rdata, .bus(bus.decoder)
	);

	irq_ctrl i_irq (
		.clk_cpu, .reset, .bus(bus.unit), .irq_ack,
		.vblank_irq, .lcd_irq, .timer_irq, .ser_irq, .joy_irq,
		.irq_n, .irq_vec, .if_rdata, .ie_rdata
	);

	joypad i_joy (
		.clk_cpu, .reset, .bus(bus.unit), .joystick, .p1_rdata, .joy_irq
	);

	serial_port #(.SER_DIV_W(SER_DIV_W)) i_serial (
		.clk_cpu, .reset, .bus(bus.unit), .sc_rdata, .ser_irq
	);

	hram i_hram (
		.clk_cpu, .bus(bus.unit), .hram_rdata
	);

endmodule

// File: include/gb_io_model.svh
// testbench model state, lfsr and reference functions for P1, IF/IE, vector and SC
`ifndef GB_IO_MODEL_SVH
`define GB_IO_MODEL_SVH

	logic [15:0]       lfsr_q = 16'd32;	// seed
	logic [DATA_W-1:0] hram_shadow [127];	// what the zero page should hold
	logic [IRQ_W-1:0]  model_if;	// expected flags
	logic [IRQ_W-1:0]  model_ie;	// expected enables

	// ----------------------------------------------------------
	// random numbers
	// ----------------------------------------------------------
	// fibonacci taps for x^16 + x^14 + x^13 + x^11
	function automatic logic lfsr_bit();
		logic fb;
		fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
		lfsr_q = {lfsr_q[14:0], fb};
		return fb;
	endfunction

	function automatic logic [7:0] rand_byte();
		logic [7:0] r;
		for (int i = 0; i < 8; i++)
			r = {r[6:0], lfsr_bit()};	// one step per bit
		return r;
	endfunction

	// zero page index, 127 folds back to 0
	function automatic logic [6:0] rand_idx();
		logic [6:0] r;
		for (int i = 0; i < 7; i++)
			r = {r[5:0], lfsr_bit()};
		if (r == 7'd127)
			r = 7'd0;
		return r;
	endfunction

	// ----------------------------------------------------------
	// expected register values
	// ----------------------------------------------------------
	function automatic logic [DATA_W-1:0] p1_model(input logic [1:0] sel, input logic [7:0] joy);
		logic [3:0] lo;
		lo = 4'hF;	// nothing pressed reads high
		for (int i = 0; i < 4; i++) begin
			if (!sel[0] && joy[i])
				lo[i] = 1'b0;	// direction pressed
			if (!sel[1] && joy[i+4])
				lo[i] = 1'b0;	// button pressed
		end
		return {2'b11, sel, lo};
	endfunction

	function automatic logic [DATA_W-1:0] vec_model(input logic [IRQ_W-1:0] f,
			input logic [IRQ_W-1:0] e);
		logic [DATA_W-1:0] v;
		logic              hit;
		v   = 8'h55;	// idle vector
		hit = 1'b0;
		for (int i = 0; i < IRQ_W; i++) begin
			if (f[i] && e[i] && !hit) begin
				v   = 8'h40 + 8'(8 * i);	// rst 40h + 8n
				hit = 1'b1;
			end
		end
		return v;
	endfunction

	function automatic logic irq_n_model(input logic [IRQ_W-1:0] f, input logic [IRQ_W-1:0] e);
		return !(|(f & e));
	endfunction

	// acknowledge drops the first enabled pending flag
	function automatic void model_ack();
		logic hit;
		hit = 1'b0;
		for (int i = 0; i < IRQ_W; i++) begin
			if (model_if[i] && model_ie[i] && !hit) begin
				model_if[i] = 1'b0;
				hit         = 1'b1;
			end
		end
	endfunction

	function automatic logic [DATA_W-1:0] if_read();
		return {3'b111, model_if};	// unused bits high
	endfunction

	function automatic logic [DATA_W-1:0] ie_read();
		return {3'b000, model_ie};
	endfunction

	function automatic logic [DATA_W-1:0] sc_model(input logic start, input logic clk_int);
		return {start, 6'h3F, clk_int};
	endfunction

`endif

// File: tests/tb_gb_io.sv
// testbench top for the i/o block: clock, reset, bus tasks, compare tasks, checker and checks
`timescale 1ns/1ps

module tb_gb_io import gb_io_pkg::*; ();

	logic              clk_cpu;
	logic              reset;
	logic [ADDR_W-1:0] cpu_addr;
	logic [DATA_W-1:0] cpu_wdata;
	logic              cpu_wr;
	logic              cpu_rd;
	logic [DATA_W-1:0] cpu_rdata;
	logic              irq_ack;
	logic              irq_n;
	logic [DATA_W-1:0] irq_vec;
	logic [7:0]        joystick;
	logic              vblank_irq;
	logic              lcd_irq;
	logic              timer_irq;

	int                err_data;	// wrong values seen
	int                err_other;	// timeouts
	string             name_q [$];	// reads waiting for the checker
	logic [DATA_W-1:0] exp_q [$];
	logic [DATA_W-1:0] act_q [$];

	`include "gb_io_model.svh"

	gb_io_top #(.SER_DIV_W(4)) i_dut (.*);	// 16 clock bit time

	initial begin
		clk_cpu = 1'b0;
		forever #50 clk_cpu = ~clk_cpu;	// 100 ns
	end

	// ----------------------------------------------------------
	// compare tasks
	// ----------------------------------------------------------
	task automatic check_byte(input string name, input logic [DATA_W-1:0] exp,
			input logic [DATA_W-1:0] act);
		if (act !== exp) begin
			err_data++;
			$display("[ERROR] %s expected %02h actual %02h", name, exp, act);
		end
	endtask

	task automatic check_vec(input string name, input logic [DATA_W-1:0] exp,
			input logic [DATA_W-1:0] act);
		if (act !== exp) begin
			err_data++;
			$display("[ERROR] %s expected vector %02h actual %02h", name, exp, act);
		end
	endtask

	task automatic check_irq_n(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			err_data++;
			$display("[ERROR] %s expected irq_n %b actual %b", name, exp, act);
		end
	endtask

	task automatic fail_other(input string what);
		err_other++;
		$display("timeout while waiting for %s", what);
	endtask

	// ----------------------------------------------------------
	// bus tasks, inputs move on the falling edge
	// ----------------------------------------------------------
	task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		@(negedge clk_cpu);
		cpu_addr  = addr;
		cpu_wdata = data;
		cpu_wr    = 1'b1;
		@(negedge clk_cpu);
		cpu_wr = 1'b0;
	endtask

	task automatic bus_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
		@(negedge clk_cpu);
		cpu_addr = addr;
		cpu_rd   = 1'b1;
		@(negedge clk_cpu);
		cpu_rd = 1'b0;
		data   = cpu_rdata;	// captured at the strobe edge, stable now
	endtask

	// queue the read for the checker
	task automatic read_expect(input string name, input logic [ADDR_W-1:0] addr,
			input logic [DATA_W-1:0] exp);
		logic [DATA_W-1:0] data;
		bus_read(addr, data);
		name_q.push_back(name);
		exp_q.push_back(exp);
		act_q.push_back(data);
	endtask

	task automatic pulse_events(input logic vb, input logic tm);
		@(negedge clk_cpu);
		vblank_irq = vb;
		timer_irq  = tm;
		@(negedge clk_cpu);
		vblank_irq = 1'b0;
		timer_irq  = 1'b0;
	endtask

	task automatic pulse_ack();
		@(negedge clk_cpu);
		irq_ack = 1'b1;
		@(negedge clk_cpu);
		irq_ack = 1'b0;	// clear lands one edge later
	endtask

	task automatic wait_vec_change(input logic [DATA_W-1:0] old);
		int n;
		n = 0;
		while (irq_vec === old && n < 20) begin
			@(negedge clk_cpu);
			n++;
		end
		if (irq_vec === old)
			fail_other("irq_vec to move after acknowledge");
	endtask

	// checker, drains queued reads
	initial begin : read_check
		string             nm;
		logic [DATA_W-1:0] e;
		logic [DATA_W-1:0] a;
		forever begin
			@(negedge clk_cpu);
			while (act_q.size() > 0) begin
				nm = name_q.pop_front();
				e  = exp_q.pop_front();
				a  = act_q.pop_front();
				check_byte(nm, e, a);
			end
		end
	end

	initial begin : main
		logic [DATA_W-1:0] data;
		logic [7:0]        joy;
		logic [6:0]        idx;
		int                n;
		err_data   = 0;
		err_other  = 0;
		reset      = 1'b1;
		cpu_addr   = '0;
		cpu_wdata  = '0;
		cpu_wr     = 1'b0;
		cpu_rd     = 1'b0;
		irq_ack    = 1'b0;
		joystick   = 8'h00;
		vblank_irq = 1'b0;
		lcd_irq    = 1'b0;
		timer_irq  = 1'b0;
		model_if   = '0;
		model_ie   = '0;
		repeat (10) @(posedge clk_cpu);
		@(negedge clk_cpu);
		reset = 1'b0;

		// fixed reads after reset
		read_expect("if_reset", ADDR_IF, if_read());
		read_expect("ie_reset", ADDR_IE, ie_read());
		read_expect("sb_open", ADDR_SB, 8'hFF);
		read_expect("unmapped_ff03", 16'hFF03, 8'hFF);

		// ----------------------------------------------------------
		// zero page ram
		// ----------------------------------------------------------
		for (int i = 0; i < 127; i++) begin
			data           = rand_byte();
			hram_shadow[i] = data;
			bus_write({9'h1FF, 7'(i)}, data);
		end
		for (int i = 0; i < 40; i++) begin	// random overwrites
			idx              = rand_idx();
			data             = rand_byte();
			hram_shadow[idx] = data;
			bus_write({9'h1FF, idx}, data);
		end
		for (int i = 0; i < 127; i++)
			read_expect("hram", {9'h1FF, 7'(i)}, hram_shadow[i]);
		model_ie = 5'h0A;
		bus_write(ADDR_IE, 8'h0A);
		read_expect("ffff_is_ie", ADDR_IE, ie_read());	// not the ram

		// ----------------------------------------------------------
		// joypad
		// ----------------------------------------------------------
		for (int i = 0; i < 8; i++) begin
			joy = rand_byte();
			@(negedge clk_cpu);
			joystick = joy;
			for (int s = 0; s < 4; s++) begin
				bus_write(ADDR_P1, {2'b00, 2'(s), 4'h0});
				read_expect("p1", ADDR_P1, p1_model(2'(s), joy));
			end
		end
		joystick = 8'h00;	// release, no edge
		model_if = '0;
		bus_write(ADDR_IF, 8'h00);
		joystick = 8'h20;	// press B
		n        = 0;
		data     = 8'h00;
		while (!data[4] && n < 20) begin
			bus_read(ADDR_IF, data);
			n++;
		end
		if (!data[4])
			fail_other("the joypad flag in IF");
		model_if[IRQ_JOYPAD] = 1'b1;
		read_expect("if_joypad", ADDR_IF, if_read());
		joystick = 8'h00;
		model_if = '0;
		bus_write(ADDR_IF, 8'h00);

		// ----------------------------------------------------------
		// interrupts, timer then vblank
		// ----------------------------------------------------------
		model_ie = 5'h1F;
		bus_write(ADDR_IE, 8'h1F);
		pulse_events(1'b0, 1'b1);
		model_if[IRQ_TIMER] = 1'b1;
		pulse_events(1'b1, 1'b0);
		model_if[IRQ_VBLANK] = 1'b1;
		check_irq_n("irq_n_pending", irq_n_model(model_if, model_ie), irq_n);
		check_vec("vec_pending", vec_model(model_if, model_ie), irq_vec);
		for (int k = 0; k < 2; k++) begin
			data = irq_vec;
			pulse_ack();
			wait_vec_change(data);
			model_ack();
			check_vec("vec_after_ack", vec_model(model_if, model_ie), irq_vec);
		end
		check_irq_n("irq_n_idle", irq_n_model(model_if, model_ie), irq_n);
		read_expect("if_acked", ADDR_IF, if_read());

		// ----------------------------------------------------------
		// serial, internal then external clock
		// ----------------------------------------------------------
		bus_write(ADDR_SC, 8'h81);
		read_expect("sc_started", ADDR_SC, sc_model(1'b1, 1'b1));
		n    = 0;
		data = 8'hFF;
		while (data[7] && n < 200) begin
			bus_read(ADDR_SC, data);
			n++;
		end
		if (data[7])
			fail_other("the serial transfer to end");
		read_expect("sc_done", ADDR_SC, sc_model(1'b0, 1'b1));
		model_if[IRQ_SERIAL] = 1'b1;
		read_expect("if_serial", ADDR_IF, if_read());
		bus_write(ADDR_SC, 8'h80);
		n    = 0;
		data = 8'hFE;
		while (data[7] && n < 100) begin	// must run out the whole time
			bus_read(ADDR_SC, data);
			n++;
		end
		if (!data[7]) begin
			err_other++;
			$display("serial start bit cleared although the external clock was selected");
		end
		read_expect("sc_external", ADDR_SC, sc_model(1'b1, 1'b0));

		// let the checker catch up
		n = 0;
		while (act_q.size() > 0 && n < 10) begin
			@(negedge clk_cpu);
			n++;
		end
		if (act_q.size() > 0)
			fail_other("the checker to drain its queue");
		$display("checks done, %0d value errors, %0d other errors", err_data, err_other);
		if (err_data == 0 && err_other == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+include
design/gb_io_pkg.sv
design/io_bus_if.sv
design/io_decode.sv
design/irq_ctrl.sv
design/joypad.sv
design/serial_port.sv
design/hram.sv
design/gb_io_top.sv
tests/tb_gb_io.sv

// File: Makefile
# Verilator build and run of the i/o block testbench

TOOL   := verilator
FLAGS  := --binary --timing --assert -j 0
TOP    := tb_gb_io
FLIST  := verilog.f
OBJDIR := obj_dir
BIN    := $(OBJDIR)/V$(TOP)
LOG    := sim.log
SRCS   := $(wildcard design/*.sv) $(wildcard tests/*.sv) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
